// ==== dma_engine.sv ====
/*
 * DMA engine top level: controller, read engine, FIFO and write engine.
 * Copies a block from an AXI4-Lite source to AXI4-Lite or tile memory.
 */
`timescale 1ns/1ps

module dma_engine import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // ==================================================
    // Command and status
    // ==================================================
    input  logic                   start_i,
    input  logic [ADDR_W-1:0]      src_i,
    input  logic [ADDR_W-1:0]      dst_i,
    input  logic [31:0]            size_i,
    output logic                   busy_o,
    output logic                   done_o,
    // ==================================================
    // AXI4-Lite master
    // ==================================================
    output logic [ADDR_W-1:0]      m_araddr_o,
    output logic                   m_arvalid_o,
    input  logic                   m_arready_i,
    input  logic [DATA_W-1:0]      m_rdata_i,
    input  logic                   m_rvalid_i,
    output logic                   m_rready_o,
    output logic [ADDR_W-1:0]      m_awaddr_o,
    output logic                   m_awvalid_o,
    input  logic                   m_awready_i,
    output logic [DATA_W-1:0]      m_wdata_o,
    output logic                   m_wvalid_o,
    input  logic                   m_wready_i,
    input  logic                   m_bvalid_i,
    output logic                   m_bready_o,
    // Tile memory port
    output logic [TILE_ADDR_W-1:0] tile_addr_o,
    output logic [TILE_BANK_W-1:0] tile_bank_o,
    output logic [DATA_W-1:0]      tile_wdata_o,
    output logic                   tile_we_o
);

    logic              go;
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dst_addr;
    logic [31:0]       word_count;
    dst_region_e       dst_region;
    logic              rd_done;
    logic              wr_done;
    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              fifo_full;
    logic              pop;
    logic [DATA_W-1:0] head_data;
    logic              fifo_empty;

    dma_xfer_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start_i(start_i), .src_i(src_i), .dst_i(dst_i),
        .size_i(size_i), .rd_done_i(rd_done), .wr_done_i(wr_done), .go_o(go),
        .src_addr_o(src_addr), .dst_addr_o(dst_addr), .word_count_o(word_count),
        .dst_region_o(dst_region), .busy_o(busy_o), .done_o(done_o)
    );

    dma_read_engine u_rd (
        .clk(clk), .rst_n(rst_n), .go_i(go), .src_addr_i(src_addr),
        .word_count_i(word_count), .fifo_full_i(fifo_full), .m_arready_i(m_arready_i),
        .m_rdata_i(m_rdata_i), .m_rvalid_i(m_rvalid_i), .m_araddr_o(m_araddr_o),
        .m_arvalid_o(m_arvalid_o), .m_rready_o(m_rready_o), .push_o(push),
        .push_data_o(push_data), .rd_done_o(rd_done)
    );

    // go also flushes whatever a previous transfer left behind
    dma_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .rst_n(rst_n), .clear_i(go), .push_i(push), .push_data_i(push_data),
        .pop_i(pop), .head_data_o(head_data), .full_o(fifo_full), .empty_o(fifo_empty)
    );

    dma_write_engine u_wr (
        .clk(clk), .rst_n(rst_n), .go_i(go), .dst_addr_i(dst_addr),
        .word_count_i(word_count), .dst_region_i(dst_region), .fifo_head_i(head_data),
        .fifo_empty_i(fifo_empty), .m_awready_i(m_awready_i), .m_wready_i(m_wready_i),
        .m_bvalid_i(m_bvalid_i), .fifo_pop_o(pop), .m_awaddr_o(m_awaddr_o),
        .m_awvalid_o(m_awvalid_o), .m_wdata_o(m_wdata_o), .m_wvalid_o(m_wvalid_o),
        .m_bready_o(m_bready_o), .tile_addr_o(tile_addr_o), .tile_bank_o(tile_bank_o),
        .tile_wdata_o(tile_wdata_o), .tile_we_o(tile_we_o), .wr_done_o(wr_done)
    );

endmodule

// ==== dma_fifo.sv ====
/*
 * Show-ahead word FIFO that decouples the read engine from the write engine.
 * The head word is visible before the pop; clear_i empties it at transfer start.
 */
`timescale 1ns/1ps

module dma_fifo import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear_i,
    input  logic              push_i,
    input  logic [DATA_W-1:0] push_data_i,
    input  logic              pop_i,
    output logic [DATA_W-1:0] head_data_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    // One extra bit so a full buffer is distinct from an empty one
    logic [PTR_W:0]    count;

    assign head_data_o = mem[rd_ptr];
    assign full_o      = (count == FIFO_DEPTH);
    assign empty_o     = (count == 0);

    // Word storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(push_i && full_o && !clear_i));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop_i && empty_o && !clear_i));

endmodule

// ==== dma_pkg.sv ====
/*
 * Shared widths, region codes and FSM state types for the DMA engine.
 * Every DMA module pulls these in with a wildcard import of dma_pkg.
 */
package dma_pkg;

    // ==================================================
    // Bus and word geometry
    // ==================================================
    localparam int DATA_W         = 32;
    localparam int ADDR_W         = 32;
    // Address step between words and divisor for size rounding
    localparam int BYTES_PER_WORD = DATA_W / 8;

    // In-bank tile address bits and the bank select above them
    localparam int TILE_ADDR_W    = 12;
    localparam int TILE_BANK_W    = 2;

    // Top nibble of the destination that selects tile memory
    localparam logic [3:0] TILE_REGION_CODE = 4'h1;

    // ==================================================
    // Enumerations
    // ==================================================
    // Any destination nibble other than the tile code selects AXI
    typedef enum logic {
        DST_AXI,
        DST_TILE
    } dst_region_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_WAIT,    // waiting for a word in the FIFO
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_TILE
    } wr_state_e;

endpackage

// ==== dma_read_engine.sv ====
/*
 * AXI4-Lite read master that fetches the source block one word at a time.
 * Each R handshake is also the FIFO push; AR waits while the FIFO is full.
 */
`timescale 1ns/1ps

module dma_read_engine import dma_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              go_i,
    input  logic [ADDR_W-1:0] src_addr_i,
    input  logic [31:0]       word_count_i,
    input  logic              fifo_full_i,
    input  logic              m_arready_i,
    input  logic [DATA_W-1:0] m_rdata_i,
    input  logic              m_rvalid_i,
    output logic [ADDR_W-1:0] m_araddr_o,
    output logic              m_arvalid_o,
    output logic              m_rready_o,
    output logic              push_o,
    output logic [DATA_W-1:0] push_data_o,
    output logic              rd_done_o
);

    rd_state_e         state;
    logic [ADDR_W-1:0] rd_addr;
    logic [31:0]       words_left;

    // Address stays put for the whole AR phase
    assign m_araddr_o  = rd_addr;
    // R handshake writes straight into the FIFO
    assign push_o      = m_rvalid_i && m_rready_o;
    assign push_data_o = m_rdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RD_IDLE;
            words_left  <= '0;
            m_arvalid_o <= 1'b0;
            m_rready_o  <= 1'b0;
            rd_done_o   <= 1'b0;
        end else begin
            rd_done_o <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (go_i) begin
                        rd_addr    <= src_addr_i;
                        words_left <= word_count_i;
                        state      <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    // Only one read in flight, so room now means room at R
                    if (!m_arvalid_o && !fifo_full_i) begin
                        m_arvalid_o <= 1'b1;
                    end
                    if (m_arvalid_o && m_arready_i) begin
                        m_arvalid_o <= 1'b0;
                        m_rready_o  <= 1'b1;
                        state       <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (push_o) begin
                        m_rready_o <= 1'b0;
                        rd_addr    <= rd_addr + ADDR_W'(BYTES_PER_WORD);
                        words_left <= words_left - 1'b1;
                        if (words_left == 32'd1) begin
                            rd_done_o <= 1'b1;
                            state     <= RD_IDLE;
                        end else begin
                            state <= RD_ADDR;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));
    a_push_room: assert property (@(posedge clk) disable iff (!rst_n)
        !(push_o && fifo_full_i));

endmodule

// ==== dma_write_engine.sv ====
/*
 * Drains the FIFO one word at a time to AXI4-Lite or to the tile port.
 * The word is popped into a holding register, then routed by region.
 * Tile writes take a single cycle; AXI writes go through AW, W and B.
 */
`timescale 1ns/1ps

module dma_write_engine import dma_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go_i,
    input  logic [ADDR_W-1:0]      dst_addr_i,
    input  logic [31:0]            word_count_i,
    input  dst_region_e            dst_region_i,
    input  logic [DATA_W-1:0]      fifo_head_i,
    input  logic                   fifo_empty_i,
    input  logic                   m_awready_i,
    input  logic                   m_wready_i,
    input  logic                   m_bvalid_i,
    output logic                   fifo_pop_o,
    output logic [ADDR_W-1:0]      m_awaddr_o,
    output logic                   m_awvalid_o,
    output logic [DATA_W-1:0]      m_wdata_o,
    output logic                   m_wvalid_o,
    output logic                   m_bready_o,
    output logic [TILE_ADDR_W-1:0] tile_addr_o,
    output logic [TILE_BANK_W-1:0] tile_bank_o,
    output logic [DATA_W-1:0]      tile_wdata_o,
    output logic                   tile_we_o,
    output logic                   wr_done_o
);

    wr_state_e         state;
    dst_region_e       region;
    // Address of the word in flight and the address of the word after it
    logic [ADDR_W-1:0] cur_addr;
    logic [ADDR_W-1:0] next_addr;
    logic [DATA_W-1:0] word_q;
    logic [31:0]       words_left;

    // Pop happens the moment a waiting engine sees data
    assign fifo_pop_o   = (state == WR_WAIT) && !fifo_empty_i;

    assign m_awaddr_o   = cur_addr;
    assign m_wdata_o    = word_q;

    // Bank from bits 13:12, in-bank address from 11:0
    assign tile_addr_o  = cur_addr[TILE_ADDR_W-1:0];
    assign tile_bank_o  = cur_addr[TILE_ADDR_W +: TILE_BANK_W];
    assign tile_wdata_o = word_q;
    assign tile_we_o    = (state == WR_TILE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= WR_IDLE;
            words_left  <= '0;
            m_awvalid_o <= 1'b0;
            m_wvalid_o  <= 1'b0;
            m_bready_o  <= 1'b0;
            wr_done_o   <= 1'b0;
        end else begin
            wr_done_o <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (go_i) begin
                        next_addr  <= dst_addr_i;
                        words_left <= word_count_i;
                        region     <= dst_region_i;
                        state      <= WR_WAIT;
                    end
                end
                WR_WAIT: begin
                    if (fifo_pop_o) begin
                        word_q     <= fifo_head_i;
                        cur_addr   <= next_addr;
                        next_addr  <= next_addr + ADDR_W'(BYTES_PER_WORD);
                        words_left <= words_left - 1'b1;
                        if (region == DST_TILE) begin
                            state <= WR_TILE;
                        end else begin
                            m_awvalid_o <= 1'b1;
                            state       <= WR_ADDR;
                        end
                    end
                end
                // Single tile write cycle
                WR_TILE: begin
                    if (words_left == '0) begin
                        wr_done_o <= 1'b1;
                        state     <= WR_IDLE;
                    end else begin
                        state <= WR_WAIT;
                    end
                end
                WR_ADDR: begin
                    if (m_awready_i) begin
                        m_awvalid_o <= 1'b0;
                        m_wvalid_o  <= 1'b1;
                        state       <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (m_wready_i) begin
                        m_wvalid_o <= 1'b0;
                        m_bready_o <= 1'b1;
                        state      <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (m_bvalid_i) begin
                        m_bready_o <= 1'b0;
                        wr_done_o  <= (words_left == '0);
                        state      <= (words_left == '0) ? WR_IDLE : WR_WAIT;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o));
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o));

endmodule

// ==== dma_xfer_ctrl.sv ====
/*
 * Transfer controller: accepts a start, rounds the size up to words,
 * decodes the destination region and launches both engines with go.
 * Busy and the done pulse come from the two engine completion flags.
 */
`timescale 1ns/1ps

module dma_xfer_ctrl import dma_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] src_i,
    input  logic [ADDR_W-1:0] dst_i,
    input  logic [31:0]       size_i,
    input  logic              rd_done_i,
    input  logic              wr_done_i,
    output logic              go_o,
    output logic [ADDR_W-1:0] src_addr_o,
    output logic [ADDR_W-1:0] dst_addr_o,
    output logic [31:0]       word_count_o,
    output dst_region_e       dst_region_o,
    output logic              busy_o,
    output logic              done_o
);

    logic        accept;
    logic [32:0] size_up;
    logic        rd_seen;
    logic        wr_seen;
    logic        both_done;

    // Zero size or a start while busy is dropped here
    assign accept    = start_i && (size_i != '0) && !busy_o;
    // Extra bit keeps the round-up from wrapping near the top of the range
    assign size_up   = {1'b0, size_i} + 33'(BYTES_PER_WORD - 1);
    assign both_done = (rd_seen || rd_done_i) && (wr_seen || wr_done_i);

    always_ff @(posedge clk) begin
        if (accept) begin
            src_addr_o   <= src_i;
            dst_addr_o   <= dst_i;
            word_count_o <= 32'(size_up / BYTES_PER_WORD);
            dst_region_o <= (dst_i[ADDR_W-1 -: 4] == TILE_REGION_CODE) ? DST_TILE : DST_AXI;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            go_o    <= 1'b0;
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
            rd_seen <= 1'b0;
            wr_seen <= 1'b0;
        end else begin
            go_o   <= accept;
            done_o <= 1'b0;
            if (accept) begin
                busy_o <= 1'b1;
            end else if (busy_o && both_done) begin
                // Last completion closes the transfer
                busy_o  <= 1'b0;
                done_o  <= 1'b1;
                rd_seen <= 1'b0;
                wr_seen <= 1'b0;
            end else begin
                rd_seen <= rd_seen || rd_done_i;
                wr_seen <= wr_seen || wr_done_i;
            end
        end
    end

    a_done_not_go: assert property (@(posedge clk) disable iff (!rst_n)
        !(done_o && go_o));

endmodule

// ==== flist.f ====
dma_pkg.sv
dma_fifo.sv
dma_read_engine.sv
dma_write_engine.sv
dma_xfer_ctrl.sv
dma_engine.sv
tb_dma_engine.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the DMA engine testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_dma_engine -Mdir obj_dir -f flist.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dma_engine > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

// ==== tb_dma_engine.sv ====
/*
 * Testbench for the DMA engine. LCG-driven transfers run against an AXI4-Lite
 * slave model with random stalls and a tile port capture, and a model checks them.
 * Compiled from flist.f and run by run.sh under Verilator.
 */
`timescale 1ns/1ps

module tb_dma_engine import dma_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int FIFO_DEPTH  = 8;
    localparam int NUM_RANDOM  = 20;
    localparam int NUM_XFERS   = NUM_RANDOM + 7;
    localparam int MAX_WORDS   = 16;
    localparam int STALL_EXTRA = 100;
    // Worst case of 40 cycles per word, plus room for reset and the stall test
    localparam int WATCHDOG_CYCLES = NUM_XFERS * MAX_WORDS * 40 + 2000;

    logic clk = 1'b0;
    logic rst_n;
    logic start_i;
    logic [ADDR_W-1:0] src_i, dst_i, m_araddr_o, m_awaddr_o;
    logic [31:0] size_i;
    logic busy_o, done_o, m_arvalid_o, m_rready_o, m_awvalid_o, m_wvalid_o, m_bready_o;
    logic m_arready_i = 1'b0;
    logic m_rvalid_i = 1'b0;
    logic m_awready_i = 1'b0;
    logic m_wready_i = 1'b0;
    logic m_bvalid_i = 1'b0;
    logic [DATA_W-1:0] m_rdata_i = '0;
    logic [DATA_W-1:0] m_wdata_o, tile_wdata_o;
    logic [TILE_ADDR_W-1:0] tile_addr_o;
    logic [TILE_BANK_W-1:0] tile_bank_o;
    logic tile_we_o;

    dma_engine #(.FIFO_DEPTH(FIFO_DEPTH)) u_dma_engine (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Random numbers, checks and bookkeeping
    // ==================================================
    logic [31:0] rng_state = 32'h495d9f89;
    string       test_name = "reset";
    int          done_count = 0;
    int          accepted = 0;
    logic [31:0] src_mem [logic [31:0]];
    logic [31:0] ar_log[$], wr_addr_log[$], wr_data_log[$];
    logic [31:0] tile_bank_log[$], tile_addr_log[$], tile_data_log[$];

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Take the upper bits since the low LCG bits repeat too fast
    function automatic int rand_below(input int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    task automatic stop_on_error();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR in %s: %s", test_name, what);
            stop_on_error();
        end
    endtask

    initial begin
        #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("ERROR in %s: watchdog expired, the transfer never finished", test_name);
        stop_on_error();
    end

    always @(negedge clk) begin
        if (rst_n && done_o) begin
            done_count++;
        end
    end

    // ==================================================
    // AXI4-Lite slave model and tile capture
    // ==================================================
    // Runs on the falling edge, so a ready or valid raised here is seen at the next rising edge
    int          ar_wait, r_wait, aw_wait, w_wait, b_wait;
    int          aw_extra = 0;
    int          stall_reads = 0;
    bit          r_pend, b_pend;
    logic [31:0] r_addr, aw_addr_q, p_araddr, p_awaddr, p_wdata;
    logic        p_arvalid, p_arready, p_awvalid, p_awready, p_wvalid, p_wready;

    always @(negedge clk) begin
        if (!rst_n) begin
            {m_arready_i, m_rvalid_i, m_awready_i, m_wready_i, m_bvalid_i} = '0;
            {p_arvalid, p_arready, p_awvalid, p_awready, p_wvalid, p_wready} = '0;
            {r_pend, b_pend} = '0;
            ar_wait = 0;
            aw_wait = 0;
            w_wait  = 0;
        end else begin
            // A valid left waiting at the last edge must still be there, unchanged
            if (p_arvalid && !p_arready) begin
                check_true(m_arvalid_o && m_araddr_o == p_araddr, "AR changed before ARREADY");
            end
            if (p_awvalid && !p_awready) begin
                check_true(m_awvalid_o && m_awaddr_o == p_awaddr, "AW changed before AWREADY");
            end
            if (p_wvalid && !p_wready) begin
                check_true(m_wvalid_o && m_wdata_o == p_wdata, "W changed before WREADY");
            end
            // R is raised only with RREADY high, so it completes at the next edge
            if (m_rvalid_i) begin
                m_rvalid_i = 1'b0;
                r_pend     = 1'b0;
            end else if (r_pend && m_rready_o) begin
                if (r_wait == 0) begin
                    check_true(src_mem.exists(r_addr), "read from an address with no data");
                    m_rvalid_i = 1'b1;
                    m_rdata_i  = src_mem[r_addr];
                end else begin
                    r_wait--;
                end
            end
            m_arready_i = 1'b0;
            if (m_arvalid_o && !r_pend) begin
                if (ar_wait == 0) begin
                    m_arready_i = 1'b1;
                    r_pend      = 1'b1;
                    r_addr      = m_araddr_o;
                    ar_log.push_back(m_araddr_o);
                    ar_wait     = rand_below(4);
                    r_wait      = rand_below(4);
                end else begin
                    ar_wait--;
                end
            end
            // Write response after the W handshake
            if (m_bvalid_i) begin
                m_bvalid_i = 1'b0;
            end else if (b_pend && m_bready_o) begin
                if (b_wait == 0) begin
                    m_bvalid_i = 1'b1;
                    b_pend     = 1'b0;
                end else begin
                    b_wait--;
                end
            end
            m_wready_i = 1'b0;
            if (m_wvalid_o) begin
                if (w_wait == 0) begin
                    m_wready_i = 1'b1;
                    wr_addr_log.push_back(aw_addr_q);
                    wr_data_log.push_back(m_wdata_o);
                    b_pend = 1'b1;
                    b_wait = rand_below(4);
                    w_wait = rand_below(4);
                end else begin
                    w_wait--;
                end
            end
            // A long AW stall lets the read side fill the FIFO
            m_awready_i = 1'b0;
            if (m_awvalid_o) begin
                if (aw_extra > 0) begin
                    aw_extra--;
                    // Reads issued by the time the stall runs out
                    if (aw_extra == 0) begin
                        stall_reads = ar_log.size();
                    end
                end else if (aw_wait > 0) begin
                    aw_wait--;
                end else begin
                    m_awready_i = 1'b1;
                    aw_addr_q   = m_awaddr_o;
                    aw_wait     = rand_below(4);
                end
            end
            if (tile_we_o) begin
                tile_bank_log.push_back(32'(tile_bank_o));
                tile_addr_log.push_back(32'(tile_addr_o));
                tile_data_log.push_back(tile_wdata_o);
            end
            {p_arvalid, p_arready, p_araddr} = {m_arvalid_o, m_arready_i, m_araddr_o};
            {p_awvalid, p_awready, p_awaddr} = {m_awvalid_o, m_awready_i, m_awaddr_o};
            {p_wvalid, p_wready, p_wdata}    = {m_wvalid_o, m_wready_i, m_wdata_o};
        end
    end

    // ==================================================
    // Test tasks
    // ==================================================
    task automatic check_idle();
        check_eq("idle outputs", 32'h0, 32'({busy_o, done_o, m_arvalid_o, m_rready_o,
            m_awvalid_o, m_wvalid_o, m_bready_o, tile_we_o}));
    endtask

    // Runs one transfer and may add a second start while busy
    task automatic run_xfer(input string name, input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] size, input bit poke_busy);
        int          words;
        logic [31:0] exp_data[$];
        logic [31:0] a;
        begin
            test_name = name;
            // ceil(size / 4) words
            words = int'(size / 32'd4) + ((size % 32'd4) != 0 ? 1 : 0);
            for (int k = 0; k < words; k++) begin
                src_mem[src + 32'(4 * k)] = next_rand();
                exp_data.push_back(src_mem[src + 32'(4 * k)]);
            end
            ar_log.delete();
            wr_addr_log.delete();
            wr_data_log.delete();
            tile_bank_log.delete();
            tile_addr_log.delete();
            tile_data_log.delete();
            start_i = 1'b1;
            src_i   = src;
            dst_i   = dst;
            size_i  = size;
            @(negedge clk);
            start_i = 1'b0;
            accepted++;
            check_true(busy_o, "busy_o did not rise after an accepted start");
            if (poke_busy) begin
                repeat (3) @(negedge clk);
                check_true(busy_o, "transfer ended before the second start");
                start_i = 1'b1;
                src_i   = 32'h0004_0000;
                dst_i   = 32'h8800_0000;
                size_i  = 32'd8;
                @(negedge clk);
                start_i = 1'b0;
            end
            while (!done_o) begin
                check_true(busy_o, "busy_o fell before done_o");
                @(negedge clk);
            end
            check_eq("busy_o during done_o", 32'h0, 32'(busy_o));
            repeat (3) @(negedge clk);
            check_eq("done pulses", 32'(accepted), 32'(done_count));
            check_eq("busy_o after done", 32'h0, 32'(busy_o));
            check_eq("read count", 32'(words), 32'(ar_log.size()));
            for (int k = 0; k < words; k++) begin
                check_eq($sformatf("read %0d address", k), src + 32'(4 * k), ar_log[k]);
            end
            if (dst[31:28] == 4'h1) begin
                check_eq("AXI write count", 32'h0, 32'(wr_addr_log.size()));
                check_eq("tile write count", 32'(words), 32'(tile_data_log.size()));
                for (int k = 0; k < words; k++) begin
                    a = dst + 32'(4 * k);
                    check_eq($sformatf("tile %0d bank", k), 32'(a[13:12]), tile_bank_log[k]);
                    check_eq($sformatf("tile %0d address", k), 32'(a[11:0]), tile_addr_log[k]);
                    check_eq($sformatf("tile %0d data", k), exp_data[k], tile_data_log[k]);
                end
            end else begin
                check_eq("tile write count", 32'h0, 32'(tile_data_log.size()));
                check_eq("AXI write count", 32'(words), 32'(wr_addr_log.size()));
                for (int k = 0; k < words; k++) begin
                    check_eq($sformatf("write %0d address", k), dst + 32'(4 * k), wr_addr_log[k]);
                    check_eq($sformatf("write %0d data", k), exp_data[k], wr_data_log[k]);
                end
            end
        end
    endtask

    task automatic zero_size_start();
        test_name = "zero_size";
        start_i   = 1'b1;
        src_i     = 32'h0003_0000;
        dst_i     = 32'h8000_0000;
        size_i    = 32'd0;
        @(negedge clk);
        start_i = 1'b0;
        repeat (6) begin
            check_idle();
            @(negedge clk);
        end
        check_eq("done pulses", 32'(accepted), 32'(done_count));
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        logic [31:0] src, dst;
        rst_n   = 1'b0;
        start_i = 1'b0;
        src_i   = '0;
        dst_i   = '0;
        size_i  = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        run_xfer("axi_to_axi", 32'h0001_0000, 32'h8000_0100, 32'd32, 1'b0);
        // Crosses from bank 1 into bank 2
        run_xfer("axi_to_tile", 32'h0001_2000, 32'h1000_1ff0, 32'd40, 1'b0);
        run_xfer("size_1", 32'h0001_4000, 32'h8000_0400, 32'd1, 1'b0);
        run_xfer("size_7", 32'h0001_5000, 32'h1000_0800, 32'd7, 1'b0);
        run_xfer("size_63", 32'h0001_6000, 32'h8000_0800, 32'd63, 1'b0);
        zero_size_start();
        run_xfer("start_while_busy", 32'h0001_7000, 32'h8000_0c00, 32'd48, 1'b1);
        aw_extra = STALL_EXTRA;
        run_xfer("write_stall", 32'h0001_8000, 32'h8000_1000, 32'd64, 1'b0);
        // The write engine holds one word and the full FIFO holds off further reads
        check_eq("reads during AW stall", 32'(FIFO_DEPTH + 1), 32'(stall_reads));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            src = 32'h0002_0000 | (next_rand() & 32'h0000_fffc);
            if (rand_below(2) == 0) begin
                dst = 32'h8000_0000 | (next_rand() & 32'h0000_fffc);
            end else begin
                dst = 32'h1000_0000 | (next_rand() & 32'h0000_3ffc);
            end
            run_xfer($sformatf("random_%0d", i), src, dst, 32'(rand_below(64) + 1), 1'b0);
        end
        test_name = "final";
        repeat (4) @(negedge clk);
        check_idle();
        check_eq("done pulses", 32'(accepted), 32'(done_count));
        $display("RESULT: PASS");
        $finish;
    end

endmodule
